/* design/ram_pkg.sv */
// ----------------------------------------------------------------------
// Shared word type, default sizing and helpers for the tiled RAM.
// Import it wherever the word type or the address width helper is needed
// ----------------------------------------------------------------------
`default_nettype none

package ram_pkg;

  // One RAM word, fixed at 16 bits for the whole design
  typedef logic [15:0] data_t;

  // Default sizing picked up by the top level
  localparam int default_depth  = 48;
  localparam int default_tiles  = 3;
  localparam int default_stages = 1;

  // Control machine state. Clearing runs once after reset, then the RAM
  // stays in the running state until the next reset
  typedef enum logic {
    CLEARING = 1'b0,
    RUNNING  = 1'b1
  } ctrl_state_e;

  // Number of address bits needed to index value entries
  // Never returns less than 1, so a single-entry space still gets a bit
  function automatic int ceil_log2(input int value);
    int width;
    width = 1;
    while ((1 << width) < value) begin
      width++;
    end
    return width;
  endfunction

endpackage : ram_pkg

`default_nettype wire

/* design/ram_tile_if.sv */
// ----------------------------------------------------------------------
// Request and response bundle for one RAM tile. The tile side takes the
// tile modport, the decoders and the read mux take the host modport
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface ram_tile_if
  import ram_pkg::*;
#(
  parameter int TileDepth = default_depth / default_tiles
) ();

  // Offset width inside one tile
  localparam int TileAddrWidth = ceil_log2(TileDepth);

  // Write request from the write decoder
  logic                     wr_valid;
  logic [TileAddrWidth-1:0] wr_addr;
  data_t                    wr_data;

  // Read request from the read decoder
  logic                     rd_valid;
  logic [TileAddrWidth-1:0] rd_addr;

  // Registered read response, one cycle after rd_valid
  logic                     rsp_valid;
  data_t                    rsp_data;

  modport tile (
    input  wr_valid, wr_addr, wr_data,
    input  rd_valid, rd_addr,
    output rsp_valid, rsp_data
  );

  modport host (
    output wr_valid, wr_addr, wr_data,
    output rd_valid, rd_addr,
    input  rsp_valid, rsp_data
  );

endinterface : ram_tile_if

`default_nettype wire

/* design/ram_addr_decoder.sv */
// ----------------------------------------------------------------------
// Steers a flat address and its data to the owning tile, with a tile
// offset. Latency is exactly Stages cycles, zero makes it combinational
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ram_addr_decoder
  import ram_pkg::*;
#(
  parameter int  Depth         = default_depth,
  parameter int  Tiles         = default_tiles,
  parameter int  Stages        = default_stages,
  localparam int TileDepth     = Depth / Tiles,
  localparam int AddrWidth     = ceil_log2(Depth),
  localparam int TileAddrWidth = ceil_log2(TileDepth)
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                in_valid,
  input  wire logic [AddrWidth-1:0]                in_addr,
  input  wire data_t                               in_data,
  output logic      [Tiles-1:0]                    out_valid,
  output logic      [Tiles-1:0][TileAddrWidth-1:0] out_addr,
  output data_t     [Tiles-1:0]                    out_data
);

  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [TileAddrWidth-1:0] tile_addr_t;

  // Depth is a power of two exactly when it has a single bit set
  localparam bit DepthIsPow2 = (Depth & (Depth - 1)) == 0;

  // Decoded request per tile, before the pipeline
  logic       [Tiles-1:0] dec_valid;
  tile_addr_t [Tiles-1:0] dec_addr;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  if (Tiles == 1) begin : gen_single
    // One tile owns everything, the offset is the address itself
    assign dec_valid[0] = in_valid && (in_addr < addr_t'(Depth));
    assign dec_addr[0]  = tile_addr_t'(in_addr);
  end else if (DepthIsPow2) begin : gen_slice
    localparam int SelWidth = AddrWidth - TileAddrWidth;
    logic [SelWidth-1:0] tile_sel;

    // The upper address bits name the tile directly
    assign tile_sel = in_addr[AddrWidth-1 -: SelWidth];

    for (genvar i = 0; i < Tiles; i++) begin : gen_tile
      assign dec_valid[i] = in_valid && (tile_sel == SelWidth'(i));
      assign dec_addr[i]  = in_addr[TileAddrWidth-1:0];
    end
  end else begin : gen_compare
    for (genvar i = 0; i < Tiles; i++) begin : gen_tile
      // Tile i owns the half-open range [base, bound)
      localparam addr_t TileBase  = addr_t'(TileDepth * i);
      localparam addr_t TileBound = addr_t'(TileDepth * (i + 1));
      addr_t offset;

      assign offset       = in_addr - TileBase;
      assign dec_valid[i] = in_valid && (in_addr >= TileBase) && (in_addr < TileBound);
      assign dec_addr[i]  = offset[TileAddrWidth-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // Output pipeline, one register chain per tile to keep fanout low
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < Tiles; i++) begin : gen_pipe
    if (Stages == 0) begin : gen_comb
      assign out_valid[i] = dec_valid[i];
      assign out_addr[i]  = dec_addr[i];
      assign out_data[i]  = in_data;
    end else begin : gen_regs
      logic [Stages-1:0] vld_q;
      tile_addr_t        addr_q [Stages];
      data_t             data_q [Stages];

      // Only the valid chain is cleared, payload follows it blindly
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          vld_q <= '0;
        end else begin
          vld_q[0] <= dec_valid[i];
          for (int s = 1; s < Stages; s++) begin
            vld_q[s] <= vld_q[s-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        addr_q[0] <= dec_addr[i];
        data_q[0] <= in_data;
        for (int s = 1; s < Stages; s++) begin
          addr_q[s] <= addr_q[s-1];
          data_q[s] <= data_q[s-1];
        end
      end

      assign out_valid[i] = vld_q[Stages-1];
      assign out_addr[i]  = addr_q[Stages-1];
      assign out_data[i]  = data_q[Stages-1];
    end
  end

endmodule : ram_addr_decoder

`default_nettype wire

/* design/ram_tile.sv */
// ----------------------------------------------------------------------
// One storage tile: flop array with a write port and a registered read
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ram_tile
  import ram_pkg::*;
#(
  parameter int TileDepth = default_depth / default_tiles
) (
  input wire logic clk,
  input wire logic rst_n,
  ram_tile_if.tile port
);

  // Word storage for this tile
  data_t mem [TileDepth];

  // ----------------------------------------------------------------------
  // Read response valid
  // ----------------------------------------------------------------------

  // High for exactly one cycle after each accepted read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      port.rsp_valid <= 1'b0;
    end else begin
      port.rsp_valid <= port.rd_valid;
    end
  end

  // ----------------------------------------------------------------------
  // Array access
  // ----------------------------------------------------------------------

  // The read samples mem before this edge's write lands, so a read and
  // write to the same offset in one cycle returns the old word
  always_ff @(posedge clk) begin
    if (port.rd_valid) begin
      port.rsp_data <= mem[port.rd_addr];
    end
    if (port.wr_valid) begin
      mem[port.wr_addr] <= port.wr_data;
    end
  end

endmodule : ram_tile

`default_nettype wire

/* design/read_data_mux.sv */
// ----------------------------------------------------------------------
// Merges the per-tile read responses into one valid and data pair.
// At most one tile answers in a cycle, so an AND-OR merge is enough
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module read_data_mux
  import ram_pkg::*;
#(
  parameter int Tiles = default_tiles
) (
  ram_tile_if.host rsp [Tiles],
  output logic     rd_data_valid,
  output data_t    rd_data
);

  // Responses pulled out of the interface array
  logic  [Tiles-1:0] tile_valid;
  data_t [Tiles-1:0] tile_data;

  // Interface array elements need constant indices, hence the loop
  for (genvar i = 0; i < Tiles; i++) begin : gen_collect
    assign tile_valid[i] = rsp[i].rsp_valid;
    assign tile_data[i]  = rsp[i].rsp_data;
  end

  // Each tile's word is masked by its own valid, so an idle cycle
  // gives zero data
  always_comb begin
    rd_data_valid = |tile_valid;
    rd_data       = '0;
    for (int i = 0; i < Tiles; i++) begin
      rd_data |= tile_data[i] & {$bits(data_t){tile_valid[i]}};
    end
  end

endmodule : read_data_mux

`default_nettype wire

/* design/ram_ctrl.sv */
// ----------------------------------------------------------------------
// Clears the RAM after reset, then passes user writes and reads to the
// decoders. init_done marks the end of clearing
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ram_ctrl
  import ram_pkg::*;
#(
  parameter int  Depth      = default_depth,
  parameter int  Stages     = default_stages,
  localparam int AddrWidth  = ceil_log2(Depth),
  localparam int ClrWidth   = ceil_log2(Depth + 1),
  localparam int DrainWidth = ceil_log2(Stages + 1)
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  // User requests
  input  wire logic                 wr_valid,
  input  wire logic [AddrWidth-1:0] wr_addr,
  input  wire data_t                wr_data,
  input  wire logic                 rd_valid,
  input  wire logic [AddrWidth-1:0] rd_addr,
  // Requests towards the write and read decoders
  output logic                      dec_wr_valid,
  output logic      [AddrWidth-1:0] dec_wr_addr,
  output data_t                     dec_wr_data,
  output logic                      dec_rd_valid,
  output logic      [AddrWidth-1:0] dec_rd_addr,
  output logic                      init_done
);

  ctrl_state_e           state;
  // Next address to clear, stops at Depth once every word is written
  logic [ClrWidth-1:0]   clr_cnt;
  // Cycles spent waiting for the last clear write to leave the pipeline
  logic [DrainWidth-1:0] drain_cnt;
  logic                  clr_write;
  logic                  drain_done;

  // A clear write goes out every cycle until the counter reaches Depth
  assign clr_write  = (state == CLEARING) && (clr_cnt < ClrWidth'(Depth));

  // Stages+1 drain cycles cover the decoder pipeline and the tile write
  assign drain_done = (clr_cnt == ClrWidth'(Depth)) && (drain_cnt == DrainWidth'(Stages));

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= CLEARING;
      clr_cnt   <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        CLEARING: begin
          if (clr_write) begin
            clr_cnt <= clr_cnt + 1'b1;
          end else if (drain_done) begin
            state <= RUNNING;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        // Running is final until the next reset
        default: state <= RUNNING;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Request steering
  // ----------------------------------------------------------------------
  assign init_done = (state == RUNNING);

  // While clearing, the write path carries zero writes and user traffic
  // is dropped on the floor
  assign dec_wr_valid = init_done ? wr_valid : clr_write;
  assign dec_wr_addr  = init_done ? wr_addr : clr_cnt[AddrWidth-1:0];
  assign dec_wr_data  = init_done ? wr_data : '0;

  // Reads need no address override, the valid alone blocks them
  assign dec_rd_valid = init_done && rd_valid;
  assign dec_rd_addr  = rd_addr;

endmodule : ram_ctrl

`default_nettype wire

/* design/tiled_ram.sv */
// ----------------------------------------------------------------------
// Tiled on-chip RAM top level. One write and one read per cycle once
// init_done is high. Read data returns Stages+1 cycles after the request
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tiled_ram
  import ram_pkg::*;
#(
  parameter int  Depth         = default_depth,
  parameter int  Tiles         = default_tiles,
  parameter int  Stages        = default_stages,
  localparam int TileDepth     = Depth / Tiles,
  localparam int AddrWidth     = ceil_log2(Depth),
  localparam int TileAddrWidth = ceil_log2(TileDepth)
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 wr_valid,
  input  wire logic [AddrWidth-1:0] wr_addr,
  input  wire data_t                wr_data,
  input  wire logic                 rd_valid,
  input  wire logic [AddrWidth-1:0] rd_addr,
  output logic                      rd_data_valid,
  output data_t                     rd_data,
  output logic                      init_done
);

  // Control block to decoders
  logic                 dec_wr_valid;
  logic [AddrWidth-1:0] dec_wr_addr;
  data_t                dec_wr_data;
  logic                 dec_rd_valid;
  logic [AddrWidth-1:0] dec_rd_addr;

  // Per-tile decoder outputs
  logic  [Tiles-1:0]                    wr_tile_valid;
  logic  [Tiles-1:0][TileAddrWidth-1:0] wr_tile_addr;
  data_t [Tiles-1:0]                    wr_tile_data;
  logic  [Tiles-1:0]                    rd_tile_valid;
  logic  [Tiles-1:0][TileAddrWidth-1:0] rd_tile_addr;

  ram_tile_if #(.TileDepth(TileDepth)) tile_bus [Tiles] ();

  ram_ctrl #(
    .Depth (Depth),
    .Stages(Stages)
  ) u_ctrl (
    .clk,
    .rst_n,
    .wr_valid,
    .wr_addr,
    .wr_data,
    .rd_valid,
    .rd_addr,
    .dec_wr_valid,
    .dec_wr_addr,
    .dec_wr_data,
    .dec_rd_valid,
    .dec_rd_addr,
    .init_done
  );

  ram_addr_decoder #(
    .Depth (Depth),
    .Tiles (Tiles),
    .Stages(Stages)
  ) u_wr_dec (
    .clk,
    .rst_n,
    .in_valid (dec_wr_valid),
    .in_addr  (dec_wr_addr),
    .in_data  (dec_wr_data),
    .out_valid(wr_tile_valid),
    .out_addr (wr_tile_addr),
    .out_data (wr_tile_data)
  );

  // Reads carry no payload, so the data lane of this decoder is idle
  ram_addr_decoder #(
    .Depth (Depth),
    .Tiles (Tiles),
    .Stages(Stages)
  ) u_rd_dec (
    .clk,
    .rst_n,
    .in_valid (dec_rd_valid),
    .in_addr  (dec_rd_addr),
    .in_data  ('0),
    .out_valid(rd_tile_valid),
    .out_addr (rd_tile_addr),
    .out_data ()
  );

  // ----------------------------------------------------------------------
  // Tiles and their request wiring
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < Tiles; i++) begin : gen_tile
    assign tile_bus[i].wr_valid = wr_tile_valid[i];
    assign tile_bus[i].wr_addr  = wr_tile_addr[i];
    assign tile_bus[i].wr_data  = wr_tile_data[i];
    assign tile_bus[i].rd_valid = rd_tile_valid[i];
    assign tile_bus[i].rd_addr  = rd_tile_addr[i];

    ram_tile #(
      .TileDepth(TileDepth)
    ) u_tile (
      .clk,
      .rst_n,
      .port(tile_bus[i])
    );
  end

  read_data_mux #(
    .Tiles(Tiles)
  ) u_mux (
    .rsp(tile_bus),
    .rd_data_valid,
    .rd_data
  );

endmodule : tiled_ram

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// ----------------------------------------------------------------------
// Testbench clock and reset source. 4 ns clock, rst_n low for 2 cycles
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int HalfPeriod  = 2,
  parameter int ResetCycles = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  // Release on a rising edge, like any other synchronous input
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

/* testbench/tiled_ram_tb.sv */
// ----------------------------------------------------------------------
// Testbench for the tiled RAM. Drives the user ports, predicts each read
// from a model array and checks data and read latency with assertions
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tiled_ram_tb
  import ram_pkg::*;
();

  localparam int Depth        = 48;
  localparam int Tiles        = 3;
  localparam int Stages       = 1;
  localparam int TileDepth    = Depth / Tiles;
  localparam int AddrWidth    = $clog2(Depth);
  localparam int DrainTimeout = Stages + 20;

  typedef logic [AddrWidth-1:0] addr_t;

  logic  clk;
  logic  rst_n;
  logic  wr_valid;
  addr_t wr_addr;
  data_t wr_data;
  logic  rd_valid;
  addr_t rd_addr;
  logic  rd_data_valid;
  data_t rd_data;
  logic  init_done;

  // Reference copy of the RAM that starts all zero like the cleared array
  data_t       model [Depth];
  // Expected responses in flight with the newest at index 0
  logic [Stages:0] pend_v;
  data_t       pend_d [Stages+1];
  logic        rd_accept;
  logic [31:0] lfsr_state;
  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;

  tb_clock_gen u_clk_gen (
    .clk,
    .rst_n
  );

  tiled_ram #(
    .Depth (Depth),
    .Tiles (Tiles),
    .Stages(Stages)
  ) u_dut (
    .clk,
    .rst_n,
    .wr_valid,
    .wr_addr,
    .wr_data,
    .rd_valid,
    .rd_addr,
    .rd_data_valid,
    .rd_data,
    .init_done
  );

  // A read only counts once clearing is over and the address exists
  assign rd_accept = rd_valid && init_done && (rd_addr < addr_t'(Depth));

  // ----------------------------------------------------------------------
  // Latency assertions
  // ----------------------------------------------------------------------
  rd_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
      rd_accept |-> ##(Stages + 1) rd_data_valid)
    else begin
      errors++;
      $display("read accepted near %0t ns got no rd_data_valid in time", $time);
    end

  rd_spurious_a: assert property (@(posedge clk) disable iff (!rst_n)
      rd_data_valid |-> $past(rd_accept, Stages + 1))
    else begin
      errors++;
      $display("rd_data_valid at %0t ns has no matching read", $time);
    end

  // ----------------------------------------------------------------------
  // Scoreboard sampled mid-cycle where inputs and outputs are settled
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    if (!rst_n) begin
      pend_v = '0;
    end else begin
      if (pend_v[Stages]) begin
        checks++;
        rd_data_a: assert (rd_data === pend_d[Stages])
          else begin
            errors++;
            $display("MISMATCH at %0t ns: rd_data expected %h got %h",
                     $time, pend_d[Stages], rd_data);
          end
      end
      for (int s = Stages; s > 0; s--) begin
        pend_v[s] = pend_v[s-1];
        pend_d[s] = pend_d[s-1];
      end
      // Reads see the array before this cycle's write lands
      pend_v[0] = rd_accept;
      pend_d[0] = rd_accept ? model[rd_addr] : '0;
      if (wr_valid && init_done && (wr_addr < addr_t'(Depth))) begin
        model[wr_addr] = wr_data;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("%s at %0t ns", why, $time);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic drive(input logic wv, input addr_t wa, input data_t wd,
                       input logic rv, input addr_t ra);
    @(posedge clk);
    wr_valid <= wv;
    wr_addr  <= wa;
    wr_data  <= wd;
    rd_valid <= rv;
    rd_addr  <= ra;
  endtask

  task automatic drive_idle();
    drive(1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!rst_n && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) abort_run("rst_n was never released");
  endtask

  task automatic wait_init_done();
    int n;
    n = 0;
    while (!init_done && n < Depth + Stages + 10) begin
      @(negedge clk);
      n++;
    end
    if (!init_done) abort_run("init_done did not rise after the clear");
  endtask

  // Waits until every expected response has been compared
  task automatic wait_drain();
    int n;
    n = 0;
    while (pend_v != '0 && n < DrainTimeout) begin
      @(negedge clk);
      n++;
    end
    if (pend_v != '0) abort_run("read responses did not drain");
  endtask

  task automatic watch_no_response(input int addr);
    for (int n = 0; n < Stages + 3; n++) begin
      @(negedge clk);
      if (rd_data_valid) begin
        errors++;
        $display("read of unmapped address %0d returned data at %0t ns", addr, $time);
      end
    end
  endtask

  task automatic report_test(input string name, input int err_mark);
    tests++;
    if (errors == err_mark) begin
      $display("test %-26s ok", name);
    end else begin
      $display("test %-26s FAILED, %0d errors", name, errors - err_mark);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int    err_mark;
    int    tile_reads [Tiles];
    addr_t wa;
    addr_t ra;
    data_t d;
    logic  wv;
    logic  rv;

    wr_valid   = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    rd_valid   = 1'b0;
    rd_addr    = '0;
    lfsr_state = 32'hb34e1eb0;
    foreach (model[i]) model[i] = '0;

    wait_reset_release();

    // Address 0 is cleared by now, so a write that leaked through the
    // clear would still be visible after init_done
    repeat (4) drive_idle();
    drive(1'b1, '0, 16'hbeef, 1'b0, '0);
    drive_idle();
    wait_init_done();

    // First and last word of every tile read back as zero
    err_mark = errors;
    for (int t = 0; t < Tiles; t++) begin
      drive(1'b0, '0, '0, 1'b1, addr_t'(t * TileDepth));
      drive(1'b0, '0, '0, 1'b1, addr_t'(t * TileDepth + TileDepth - 1));
    end
    drive_idle();
    wait_drain();
    report_test("clear after reset", err_mark);

    err_mark = errors;
    drive(1'b0, '0, '0, 1'b1, '0);
    drive_idle();
    wait_drain();
    report_test("write during clear", err_mark);

    // Mixed random writes and reads over the whole map
    err_mark = errors;
    foreach (tile_reads[t]) tile_reads[t] = 0;
    repeat (300) begin
      wv = (take_bits(1) != 0);
      wa = addr_t'(take_bits(AddrWidth) % Depth);
      d  = data_t'(take_bits(16));
      rv = (take_bits(1) != 0);
      ra = addr_t'(take_bits(AddrWidth) % Depth);
      if (rv) tile_reads[ra / TileDepth]++;
      drive(wv, wa, d, rv, ra);
    end
    drive_idle();
    wait_drain();
    foreach (tile_reads[t]) begin
      if (tile_reads[t] == 0) begin
        errors++;
        $display("random traffic never read from tile %0d", t);
      end
    end
    report_test("random traffic", err_mark);

    // Unmapped addresses give no response and disturb no stored word
    err_mark = errors;
    for (int a = Depth; a < (1 << AddrWidth); a++) begin
      drive(1'b1, addr_t'(a), data_t'(take_bits(16)), 1'b1, addr_t'(a));
      drive_idle();
      watch_no_response(a);
    end
    for (int a = 0; a < Depth; a++) begin
      drive(1'b0, '0, '0, 1'b1, addr_t'(a));
    end
    drive_idle();
    wait_drain();
    report_test("out of range", err_mark);

    // The same-cycle pair returns the old word and the next read the new one
    err_mark = errors;
    wa = addr_t'(33);
    d  = ~model[33];
    drive(1'b1, wa, d, 1'b1, wa);
    drive(1'b0, '0, '0, 1'b1, wa);
    drive_idle();
    wait_drain();
    report_test("same-cycle read and write", err_mark);

    $display("%0d tests, %0d read checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tiled_ram_tb

`default_nettype wire

/* sim.f */
design/ram_pkg.sv
design/ram_tile_if.sv
design/ram_addr_decoder.sv
design/ram_tile.sv
design/read_data_mux.sv
design/ram_ctrl.sv
design/tiled_ram.sv
testbench/tb_clock_gen.sv
testbench/tiled_ram_tb.sv

/* Bender.yml */
package:
  name: tiled_ram

sources:
  # RTL in compile order
  - files:
      - design/ram_pkg.sv
      - design/ram_tile_if.sv
      - design/ram_addr_decoder.sv
      - design/ram_tile.sv
      - design/read_data_mux.sv
      - design/ram_ctrl.sv
      - design/tiled_ram.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tiled_ram_tb.sv
